// File: ctrlDecoder.f
src/rvIsaPkg.sv
src/ctrlPkg.sv
src/aluDecode.sv
src/memDecode.sv
src/flowDecode.sv
src/sysDecode.sv
src/instrDecode.sv
src/decodeHandshake.sv
src/ctrlDecoder.sv
sim/tbClock.sv
sim/ctrlDecoderTb.sv

// File: Bender.yml
package:
  name: ctrl_decoder

sources:
  - src/rvIsaPkg.sv
  - src/ctrlPkg.sv
  - src/aluDecode.sv
  - src/memDecode.sv
  - src/flowDecode.sv
  - src/sysDecode.sv
  - src/instrDecode.sv
  - src/decodeHandshake.sv
  - src/ctrlDecoder.sv
  - target: test
    files:
      - sim/tbClock.sv
      - sim/ctrlDecoderTb.sv

// File: sim/ctrlDecoderTb.sv
// directed tests for the decoder top
// reference model of the decode rules, value checker, cycle timeout
`default_nettype none

module ctrlDecoderTb
  import ctrlPkg::*, rvIsaPkg::*;
();

  localparam bit rv64Cfg        = 1'b1;
  localparam int handshakeCount = 64 + 28 + 6 + 1 + 27;  // alu, mem/flow, sys, hold, illegal
  localparam int cycleLimit     = 40 * handshakeCount;

  logic        clk;
  logic        rstN;
  logic        req;
  instr_u      instr;
  logic        ack;
  ctrlWord_t   ctrl;

  logic [31:0] lcgState   = 32'd84;
  logic [31:0] curInstr   = '0;     // word under test, for error lines
  string       curTest    = "reset";
  int          checkCount = 0;
  int          errorCount = 0;
  int          cycleCount = 0;

  tbClock #(.Period(8), .ResetCycles(3)) uClock (.clk(clk), .rstN(rstN));

  ctrlDecoder #(.Rv64(rv64Cfg)) UUT (
    .clk  (clk),
    .rstN (rstN),
    .req  (req),
    .instr(instr),
    .ack  (ack),
    .ctrl (ctrl)
  );

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("timeout: run went past %0d cycles in %s", cycleLimit, curTest);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // random rd/rs1/rs2, given funct7
  function automatic logic [31:0] regForm(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [6:0] f7);
    logic [31:0] r;
    r = nextRand();
    return {f7, r[24:15], f3, r[11:7], op};
  endfunction

  // random imm12/rs1/rd
  function automatic logic [31:0] immForm(input logic [6:0] op, input logic [2:0] f3);
    logic [31:0] r;
    r = nextRand();
    return {r[31:15], f3, r[11:7], op};
  endfunction

  // expected control word straight from the decode rules
  function automatic ctrlWord_t expectCtrl(input logic [31:0] w);
    ctrlWord_t   e;
    logic        bad;
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        isSub;
    logic        isSra;
    e     = '0;
    bad   = 1'b0;
    op    = w[6:0];
    f3    = w[14:12];
    f7    = w[31:25];
    isSub = ((op == opReg) || (op == opReg32)) && (f7 == f7Alt) && (f3 == 3'b000);
    isSra = w[30] && (f3 == 3'b101);
    case (op)
      opLui, opAuipc: begin
        e.aluSrcA = (op == opLui) ? srcRs1 : srcPc;
        e.aluSrcB = srcImm;
        e.immFmt  = fmtU;
        e.aluOp   = (op == opLui) ? aluPassB : aluAdd;
        e.regWen  = 1'b1;
      end
      opJal, opJalr: begin
        e.aluSrcA = srcPc;
        e.aluSrcB = srcFour;
        e.immFmt  = (op == opJal) ? fmtJ : fmtI;
        e.branch  = (op == opJal) ? brJal : brJalr;
        e.regWen  = 1'b1;
      end
      opImm, opReg, opImm32, opReg32: begin
        e.aluSrcA = srcRs1;
        e.regWen  = 1'b1;
        if ((op == opImm) || (op == opImm32)) begin
          e.aluSrcB = srcImm;
          e.immFmt  = fmtI;
        end else begin
          e.aluSrcB = srcRs2;
          e.immFmt  = fmtR;
          bad       = (f7 == f7Mext);    // M ext not supported
        end
        if ((op == opImm32) || (op == opReg32)) begin
          case (f3)
            3'b000:  e.aluOp = isSub ? aluSubW : aluAddW;
            3'b001:  e.aluOp = aluSllW;
            3'b101:  e.aluOp = isSra ? aluSraW : aluSrlW;
            default: bad = 1'b1;
          endcase
          if (!rv64Cfg) bad = 1'b1;
        end else begin
          case (f3)
            3'b000:  e.aluOp = isSub ? aluSub : aluAdd;
            3'b001:  e.aluOp = aluSll;
            3'b010:  e.aluOp = aluSlt;
            3'b011:  e.aluOp = aluSltu;
            3'b100:  e.aluOp = aluXor;
            3'b101:  e.aluOp = isSra ? aluSra : aluSrl;
            3'b110:  e.aluOp = aluOr;
            default: e.aluOp = aluAnd;
          endcase
        end
      end
      opBranch: begin
        e.aluSrcA = srcRs1;
        e.aluSrcB = srcRs2;
        e.immFmt  = fmtB;
        e.aluOp   = f3[1] ? aluSltu : aluSlt;  // 11x unsigned
        case (f3)
          3'b000:         e.branch = brEq;
          3'b001:         e.branch = brNe;
          3'b100, 3'b110: e.branch = brLt;
          3'b101, 3'b111: e.branch = brGe;
          default:        bad = 1'b1;
        endcase
      end
      opLoad, opStore: begin
        e.aluSrcA = srcRs1;
        e.aluSrcB = srcImm;
        e.immFmt  = (op == opLoad) ? fmtI : fmtS;
        e.memToReg = (op == opLoad);
        e.regWen   = (op == opLoad);
        e.memWen   = (op == opStore);
        case (f3)
          3'b000:  e.memOp = memB;
          3'b001:  e.memOp = memH;
          3'b010:  e.memOp = memW;
          3'b011:  e.memOp = memD;
          3'b100:  e.memOp = memBu;
          3'b101:  e.memOp = memHu;
          3'b110:  e.memOp = memWu;
          default: bad = 1'b1;
        endcase
        if ((op == opStore) && f3[2]) bad = 1'b1;  // no unsigned stores
      end
      opSystem: begin
        e.aluSrcA = srcRs1;
        e.aluSrcB = srcImm;
        e.immFmt  = fmtI;
        case (f3)
          3'b000: begin
            e.ecall  = (w[31:20] == immEcall);
            e.ebreak = (w[31:20] == immEbreak);
            e.mret   = (w[31:20] == immMret);
            bad      = !(e.ecall || e.ebreak || e.mret);
          end
          3'b001, 3'b010, 3'b011: begin
            e.csrWen   = 1'b1;
            e.csrToReg = 1'b1;
            e.regWen   = 1'b1;
            e.csrOp    = (f3 == 3'b010) ? csrSet : (f3 == 3'b011) ? csrClear : csrWrite;
          end
          default: bad = 1'b1;
        endcase
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      e         = '0;
      e.illegal = 1'b1;  // only the flag survives
    end
    return e;
  endfunction

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("FAILED %s got 0x%0h expected 0x%0h (%s, instr 0x%08h)",
               name, got, exp, curTest, curInstr);
    end
  endtask

  // raise req, wait for ack, check its latency
  task automatic startRequest(input logic [31:0] w);
    int edges;
    edges = 0;
    curInstr = w;
    @(posedge clk);
    req   <= 1'b1;
    instr <= w;
    do begin
      @(posedge clk);
      edges++;
      @(negedge clk);                  // sample away from the edge
    end while (!ack && (edges < 8));
    if (!ack) begin
      errorCount++;
      $display("no ack from the DUT within %0d edges in %s", edges, curTest);
    end else begin
      checkValue("ackLatency", edges, 2);
    end
  endtask

  // drop req, ack must follow at the next edge
  task automatic endRequest();
    int edges;
    edges = 0;
    @(posedge clk);
    req   <= 1'b0;
    instr <= nextRand();               // garbage while idle
    do begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (ack && (edges < 8));
    if (ack) begin
      errorCount++;
      $display("ack stayed high after req dropped in %s", curTest);
    end else begin
      checkValue("ackFall", edges, 1);
    end
  endtask

  task automatic runHandshake(input logic [31:0] w);
    startRequest(w);
    checkValue("ctrl", ctrl, expectCtrl(w));
    endRequest();
  endtask

  task automatic aluOpSweep();
    logic [6:0]  op;
    logic [31:0] w;
    curTest = "alu ops";
    for (int k = 0; k < 4; k++) begin
      case (k)
        0:       op = opImm;
        1:       op = opReg;
        2:       op = opImm32;
        default: op = opReg32;
      endcase
      for (int f3 = 0; f3 < 8; f3++) begin
        for (int alt = 0; alt < 2; alt++) begin
          if ((op == opReg) || (op == opReg32)) begin
            w = regForm(op, 3'(f3), (alt != 0) ? f7Alt : f7Base);
          end else begin
            w     = immForm(op, 3'(f3));
            w[30] = (alt != 0);        // srai/sraiw select
          end
          runHandshake(w);
        end
      end
    end
  endtask

  task automatic memFlowSweep();
    curTest = "upper imm and jumps";
    runHandshake(immForm(opLui, 3'd5));
    runHandshake(immForm(opAuipc, 3'd2));
    runHandshake(immForm(opJal, 3'd7));
    runHandshake(immForm(opJalr, 3'd0));
    curTest = "branches";
    for (int f3 = 0; f3 < 8; f3++) runHandshake(regForm(opBranch, 3'(f3), 7'h2a));
    curTest = "loads";
    for (int f3 = 0; f3 < 8; f3++) runHandshake(immForm(opLoad, 3'(f3)));
    curTest = "stores";
    for (int f3 = 0; f3 < 8; f3++) runHandshake(regForm(opStore, 3'(f3), 7'h51));
  endtask

  task automatic systemOps();
    curTest = "csr ops";
    for (int f3 = 1; f3 < 4; f3++) runHandshake(immForm(opSystem, 3'(f3)));
    curTest = "traps";
    runHandshake({immEcall, 13'b0, opSystem});
    runHandshake({immEbreak, 13'b0, opSystem});
    runHandshake({immMret, 13'b0, opSystem});
  endtask

  // req held high, instr changes underneath
  task automatic backPressure();
    logic [31:0] w;
    ctrlWord_t   exp;
    curTest = "back-pressure";
    w   = regForm(opReg32, 3'b101, f7Alt);  // sraw
    exp = expectCtrl(w);
    startRequest(w);
    repeat (20) begin
      @(posedge clk);
      instr <= immForm(opLoad, 3'b011);
      @(negedge clk);
      checkValue("ack", ack, 1);
      checkValue("ctrl", ctrl, exp);
    end
    endRequest();
  endtask

  task automatic illegalWords();
    curTest = "unknown opcodes";
    runHandshake(immForm(7'b0000000, 3'd2));
    runHandshake(immForm(7'b1111111, 3'd6));
    runHandshake(immForm(7'b0001111, 3'd0));  // fence, not decoded
    runHandshake(immForm(7'b1010011, 3'd1));
    curTest = "M extension";
    for (int f3 = 0; f3 < 8; f3++) begin
      runHandshake(regForm(opReg, 3'(f3), f7Mext));
      runHandshake(regForm(opReg32, 3'(f3), f7Mext));
    end
    curTest = "bad system imm";
    runHandshake({12'h105, 13'b0, opSystem});  // wfi
    runHandshake({12'h102, 13'b0, opSystem});  // sret
    runHandshake({12'h7ff, 13'b0, opSystem});
    curTest = "csr imm forms";
    for (int f3 = 4; f3 < 8; f3++) runHandshake(immForm(opSystem, 3'(f3)));
  endtask

  initial begin
    req   = 1'b0;
    instr = '0;
    @(posedge rstN);
    @(negedge clk);
    checkValue("ack", ack, 0);         // idle after reset
    checkValue("ctrl", ctrl, 0);
    aluOpSweep();
    memFlowSweep();
    systemOps();
    backPressure();
    illegalWords();
    $display("checks %0d errors %0d cycles %0d", checkCount, errorCount, cycleCount);
    if (errorCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/tbClock.sv
// testbench clock and reset source
// free-running clock, active-low reset for a few cycles
`default_nettype none

module tbClock #(
  parameter int Period      = 8,
  parameter int ResetCycles = 3
) (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #(Period / 2) clk = ~clk;
  end

  initial begin
    rstN = 1'b0;                    // low from time zero
    repeat (ResetCycles) @(posedge clk);
    rstN <= 1'b1;                   // release on an edge
  end

endmodule

`default_nettype wire

// File: src/ctrlDecoder.sv
// decoder top
// req/ack stage around the combinational instruction decode
`default_nettype none

module ctrlDecoder
  import ctrlPkg::*, rvIsaPkg::*;
#(
  parameter bit Rv64 = 1'b1  // 0 rejects word opcodes
) (
  input  logic      clk,
  input  logic      rstN,
  input  logic      req,
  input  instr_u    instr,
  output logic      ack,
  output ctrlWord_t ctrl
);

  instr_u    heldInstr;  // captured on accept
  ctrlWord_t decoded;

  decodeHandshake uHandshake (
    .clk      (clk),
    .rstN     (rstN),
    .req      (req),
    .instr    (instr),
    .ack      (ack),
    .heldInstr(heldInstr),
    .decoded  (decoded),
    .ctrl     (ctrl)
  );

  instrDecode #(.Rv64(Rv64)) uDecode (
    .instr(heldInstr),
    .ctrl (decoded)
  );

endmodule

`default_nettype wire

// File: src/decodeHandshake.sv
// four-phase req/ack stage
// holds the accepted instruction, then the decoded control word
`default_nettype none

module decodeHandshake
  import ctrlPkg::*, rvIsaPkg::*;
(
  input  logic      clk,
  input  logic      rstN,
  input  logic      req,
  input  instr_u    instr,
  output logic      ack,
  output instr_u    heldInstr,
  input  ctrlWord_t decoded,
  output ctrlWord_t ctrl
);

  typedef enum logic {
    stIdle,
    stBusy   // instruction held, decode settling
  } state_e;

  state_e state;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state     <= stIdle;
      ack       <= 1'b0;
      heldInstr <= '0;
      ctrl      <= ctrlZero;
    end else begin
      case (state)
        stIdle: begin
          if (req && !ack) begin       // new request, previous ack gone
            heldInstr <= instr;
            state     <= stBusy;
          end else if (!req) begin
            ack <= 1'b0;               // return to zero phase
          end
        end
        default: begin
          ctrl  <= decoded;
          ack   <= 1'b1;
          state <= stIdle;             // wait for req low there
        end
      endcase
    end
  end

  ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
    $rose(ack) |-> $past(req))
    else $error("decodeHandshake: ack raised after req was withdrawn");

  ctrlHeld: assert property (@(posedge clk) disable iff (!rstN)
    ($past(ack) && ack) |-> $stable(ctrl))
    else $error("decodeHandshake: ctrl changed during ack");

endmodule

`default_nettype wire

// File: src/instrDecode.sv
// full instruction decode
// picks one sub-decoder word by opcode class, cleans illegal words
`default_nettype none

module instrDecode
  import ctrlPkg::*, rvIsaPkg::*;
#(
  parameter bit Rv64 = 1'b1
) (
  input  instr_u    instr,
  output ctrlWord_t ctrl
);

  ctrlWord_t aluCtrl;
  ctrlWord_t memCtrl;
  ctrlWord_t flowCtrl;
  ctrlWord_t sysCtrl;
  ctrlWord_t selCtrl;  // before illegal cleanup

  aluDecode #(.Rv64(Rv64)) uAlu (.instr(instr), .ctrl(aluCtrl));
  memDecode                uMem (.instr(instr), .ctrl(memCtrl));
  flowDecode               uFlow (.instr(instr), .ctrl(flowCtrl));
  sysDecode                uSys (.instr(instr), .ctrl(sysCtrl));

  always_comb begin
    case (instr.r.opcode)
      opLui, opAuipc, opImm, opReg:  selCtrl = aluCtrl;
      opImm32, opReg32:              selCtrl = Rv64 ? aluCtrl : ctrlIllegal;
      opLoad, opStore:               selCtrl = memCtrl;
      opJal, opJalr, opBranch:       selCtrl = flowCtrl;
      opSystem:                      selCtrl = sysCtrl;
      default:                       selCtrl = ctrlIllegal;  // unknown opcode
    endcase
    // no side effects may leak from a rejected instruction
    ctrl = selCtrl.illegal ? ctrlIllegal : selCtrl;
  end

  trapOneHot: assert final ($onehot0({ctrl.ecall, ctrl.ebreak, ctrl.mret}))
    else $error("instrDecode: more than one trap flag set");

endmodule

`default_nettype wire

// File: src/sysDecode.sv
// system opcode decode
// csrrw/csrrs/csrrc by funct3, ecall/ebreak/mret by imm12
`default_nettype none

module sysDecode
  import ctrlPkg::*, rvIsaPkg::*;
(
  input  instr_u    instr,
  output ctrlWord_t ctrl
);

  always_comb begin
    ctrl         = ctrlZero;
    ctrl.aluSrcA = srcRs1;
    ctrl.aluSrcB = srcImm;
    ctrl.immFmt  = fmtI;
    ctrl.aluOp   = aluAdd;
    if (instr.i.opcode != opSystem) begin
      ctrl.illegal = 1'b1;
    end else begin
      case (instr.i.funct3)
        f3Priv: begin
          case (instr.i.imm12)
            immEcall:  ctrl.ecall  = 1'b1;
            immEbreak: ctrl.ebreak = 1'b1;
            immMret:   ctrl.mret   = 1'b1;
            default:   ctrl.illegal = 1'b1;  // wfi, sret etc
          endcase
        end
        f3Csrrw, f3Csrrs, f3Csrrc: begin
          ctrl.csrWen   = 1'b1;
          ctrl.csrToReg = 1'b1;  // rd gets old csr
          ctrl.regWen   = 1'b1;
          case (instr.i.funct3)
            f3Csrrs: ctrl.csrOp = csrSet;
            f3Csrrc: ctrl.csrOp = csrClear;
            default: ctrl.csrOp = csrWrite;
          endcase
        end
        default: ctrl.illegal = 1'b1;  // csr*i forms too
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/flowDecode.sv
// control flow decode for jal, jalr and conditional branches
`default_nettype none

module flowDecode
  import ctrlPkg::*, rvIsaPkg::*;
(
  input  instr_u    instr,
  output ctrlWord_t ctrl
);

  always_comb begin
    ctrl = ctrlZero;
    case (instr.r.opcode)
      opJal, opJalr: begin
        ctrl.aluSrcA = srcPc;
        ctrl.aluSrcB = srcFour;  // rd <= pc + 4
        ctrl.aluOp   = aluAdd;
        ctrl.regWen  = 1'b1;
        ctrl.immFmt  = (instr.r.opcode == opJal) ? fmtJ : fmtI;
        ctrl.branch  = (instr.r.opcode == opJal) ? brJal : brJalr;
      end
      opBranch: begin
        ctrl.aluSrcA = srcRs1;
        ctrl.aluSrcB = srcRs2;
        ctrl.immFmt  = fmtB;
        ctrl.aluOp   = aluSlt;   // signed compare by default
        case (instr.r.funct3)
          f3Beq:  ctrl.branch = brEq;
          f3Bne:  ctrl.branch = brNe;
          f3Blt:  ctrl.branch = brLt;
          f3Bge:  ctrl.branch = brGe;
          f3Bltu: begin
            ctrl.branch = brLt;
            ctrl.aluOp  = aluSltu;
          end
          f3Bgeu: begin
            ctrl.branch = brGe;
            ctrl.aluOp  = aluSltu;
          end
          default: ctrl.illegal = 1'b1;  // 010, 011 unused
        endcase
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: src/memDecode.sv
// load and store decode
// address is rs1 + imm, width and sign from funct3
`default_nettype none

module memDecode
  import ctrlPkg::*, rvIsaPkg::*;
(
  input  instr_u    instr,
  output ctrlWord_t ctrl
);

  always_comb begin
    ctrl         = ctrlZero;
    ctrl.aluSrcA = srcRs1;
    ctrl.aluSrcB = srcImm;
    ctrl.aluOp   = aluAdd;  // effective address
    case (instr.r.opcode)
      opLoad: begin
        ctrl.immFmt   = fmtI;
        ctrl.memToReg = 1'b1;
        ctrl.regWen   = 1'b1;
        case (instr.i.funct3)
          f3Byte:  ctrl.memOp = memB;
          f3Half:  ctrl.memOp = memH;
          f3Word:  ctrl.memOp = memW;
          f3Dword: ctrl.memOp = memD;
          f3ByteU: ctrl.memOp = memBu;  // zero extend
          f3HalfU: ctrl.memOp = memHu;
          f3WordU: ctrl.memOp = memWu;
          default: ctrl.illegal = 1'b1;
        endcase
      end
      opStore: begin
        ctrl.immFmt = fmtS;
        ctrl.memWen = 1'b1;
        case (instr.s.funct3)
          f3Byte:  ctrl.memOp = memB;
          f3Half:  ctrl.memOp = memH;
          f3Word:  ctrl.memOp = memW;
          f3Dword: ctrl.memOp = memD;
          default: ctrl.illegal = 1'b1;  // no unsigned stores
        endcase
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

  loadStoreExcl: assert final (!(ctrl.memWen && ctrl.memToReg))
    else $error("memDecode: store word also requests load write-back");

endmodule

`default_nettype wire

// File: src/aluDecode.sv
// integer ALU decode for OP, OP-IMM, OP-32, OP-IMM-32
// plus lui and auipc
`default_nettype none

module aluDecode
  import ctrlPkg::*, rvIsaPkg::*;
#(
  parameter bit Rv64 = 1'b1
) (
  input  instr_u    instr,
  output ctrlWord_t ctrl
);

  logic   isReg;   // register-register form
  logic   isWord;  // 32-bit result form
  logic   subSel;
  logic   sraSel;
  aluOp_e baseOp;  // 64-bit code from funct3

  assign isReg  = (instr.r.opcode == opReg) || (instr.r.opcode == opReg32);
  assign isWord = (instr.r.opcode == opImm32) || (instr.r.opcode == opReg32);
  assign subSel = isReg && (instr.r.funct7 == f7Alt);  // no subi
  assign sraSel = instr.r.funct7[5];                    // bit 30, srai too

  always_comb begin
    case (instr.r.funct3)
      f3AddSub: baseOp = subSel ? aluSub : aluAdd;
      f3Sll:    baseOp = aluSll;
      f3Slt:    baseOp = aluSlt;
      f3Sltu:   baseOp = aluSltu;
      f3Xor:    baseOp = aluXor;
      f3SrlSra: baseOp = sraSel ? aluSra : aluSrl;
      f3Or:     baseOp = aluOr;
      default:  baseOp = aluAnd;
    endcase
  end

  always_comb begin
    ctrl         = ctrlZero;
    ctrl.aluSrcA = srcRs1;
    ctrl.regWen  = 1'b1;         // every op here writes rd
    ctrl.aluOp   = baseOp;
    case (instr.r.opcode)
      opLui: begin
        ctrl.aluSrcB = srcImm;
        ctrl.immFmt  = fmtU;
        ctrl.aluOp   = aluPassB;
      end
      opAuipc: begin
        ctrl.aluSrcA = srcPc;
        ctrl.aluSrcB = srcImm;
        ctrl.immFmt  = fmtU;
        ctrl.aluOp   = aluAdd;
      end
      opImm, opImm32: begin
        ctrl.aluSrcB = srcImm;
        ctrl.immFmt  = fmtI;
      end
      opReg, opReg32: begin
        ctrl.aluSrcB = srcRs2;
        ctrl.immFmt  = fmtR;
        ctrl.illegal = (instr.r.funct7 == f7Mext);  // M ext dropped
      end
      default: ctrl.illegal = 1'b1;
    endcase
    if (isWord) begin
      case (baseOp)
        aluAdd:  ctrl.aluOp = aluAddW;
        aluSub:  ctrl.aluOp = aluSubW;
        aluSll:  ctrl.aluOp = aluSllW;
        aluSrl:  ctrl.aluOp = aluSrlW;
        aluSra:  ctrl.aluOp = aluSraW;
        default: ctrl.illegal = 1'b1;  // no word slt/xor/or/and
      endcase
      if (!Rv64) begin
        ctrl.illegal = 1'b1;           // RV32 has no word forms
      end
    end
  end

endmodule

`default_nettype wire

// File: src/ctrlPkg.sv
// control word for execute, memory, write-back and CSR stages
// operand, immediate, ALU, memory, branch and CSR encodings
`default_nettype none

package ctrlPkg;

  typedef enum logic {
    srcPc  = 1'b0,
    srcRs1 = 1'b1
  } aluSrcA_e;

  typedef enum logic [1:0] {
    srcRs2  = 2'd0,
    srcImm  = 2'd1,
    srcFour = 2'd2   // link address pc+4
  } aluSrcB_e;

  typedef enum logic [2:0] {
    fmtI = 3'd0,
    fmtU = 3'd1,
    fmtS = 3'd2,
    fmtB = 3'd3,
    fmtJ = 3'd4,
    fmtR = 3'd5
  } immFmt_e;

  // low 3 bits follow funct3, bit 3 alt op, bit 4 word form
  typedef enum logic [4:0] {
    aluAdd   = 5'd0,
    aluSll   = 5'd1,
    aluSlt   = 5'd2,
    aluSltu  = 5'd3,
    aluXor   = 5'd4,
    aluSrl   = 5'd5,
    aluOr    = 5'd6,
    aluAnd   = 5'd7,
    aluSub   = 5'd8,
    aluSra   = 5'd13,
    aluPassB = 5'd15,  // lui
    aluAddW  = 5'd16,
    aluSllW  = 5'd17,
    aluSrlW  = 5'd21,
    aluSubW  = 5'd24,
    aluSraW  = 5'd29
  } aluOp_e;

  typedef enum logic [2:0] {
    memW  = 3'd0,
    memB  = 3'd1,
    memH  = 3'd2,
    memD  = 3'd3,
    memWu = 3'd4,
    memBu = 3'd5,
    memHu = 3'd6
  } memOp_e;

  typedef enum logic [2:0] {
    brNone = 3'd0,
    brJal  = 3'd1,
    brJalr = 3'd2,
    brEq   = 3'd4,
    brNe   = 3'd5,
    brLt   = 3'd6,  // also bltu
    brGe   = 3'd7   // also bgeu
  } branch_e;

  typedef enum logic [1:0] {
    csrWrite = 2'd0,
    csrSet   = 2'd1,
    csrClear = 2'd2
  } csrOp_e;

  typedef struct packed {
    aluSrcA_e aluSrcA;
    aluSrcB_e aluSrcB;
    immFmt_e  immFmt;
    aluOp_e   aluOp;
    branch_e  branch;
    memOp_e   memOp;
    logic     memToReg;  // load data to rd
    logic     regWen;
    logic     memWen;
    logic     csrWen;
    logic     csrToReg;  // old csr value to rd
    csrOp_e   csrOp;
    logic     ecall;
    logic     ebreak;
    logic     mret;
    logic     illegal;   // lsb
  } ctrlWord_t;

  localparam ctrlWord_t ctrlZero    = '0;
  localparam ctrlWord_t ctrlIllegal = ctrlWord_t'(1);  // only illegal set

endpackage

`default_nettype wire

// File: src/rvIsaPkg.sv
// RV64I base encodings
// major opcodes, funct3 and funct7 codes, system immediates
// R/I/S/U views of one instruction word
`default_nettype none

package rvIsaPkg;

  typedef enum logic [6:0] {
    opLui    = 7'b0110111,
    opAuipc  = 7'b0010111,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opBranch = 7'b1100011,
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opImm    = 7'b0010011,
    opReg    = 7'b0110011,
    opImm32  = 7'b0011011,  // RV64 only
    opReg32  = 7'b0111011,  // RV64 only
    opSystem = 7'b1110011
  } opcode_e;

  // integer ops
  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Sll    = 3'b001;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Sltu   = 3'b011;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3SrlSra = 3'b101;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;

  // branches
  localparam logic [2:0] f3Beq  = 3'b000;
  localparam logic [2:0] f3Bne  = 3'b001;
  localparam logic [2:0] f3Blt  = 3'b100;
  localparam logic [2:0] f3Bge  = 3'b101;
  localparam logic [2:0] f3Bltu = 3'b110;
  localparam logic [2:0] f3Bgeu = 3'b111;

  // loads, stores reuse the low four
  localparam logic [2:0] f3Byte  = 3'b000;
  localparam logic [2:0] f3Half  = 3'b001;
  localparam logic [2:0] f3Word  = 3'b010;
  localparam logic [2:0] f3Dword = 3'b011;
  localparam logic [2:0] f3ByteU = 3'b100;
  localparam logic [2:0] f3HalfU = 3'b101;
  localparam logic [2:0] f3WordU = 3'b110;

  // system
  localparam logic [2:0] f3Priv  = 3'b000;
  localparam logic [2:0] f3Csrrw = 3'b001;
  localparam logic [2:0] f3Csrrs = 3'b010;
  localparam logic [2:0] f3Csrrc = 3'b011;

  localparam logic [6:0] f7Base = 7'b0000000;
  localparam logic [6:0] f7Alt  = 7'b0100000;  // sub / sra
  localparam logic [6:0] f7Mext = 7'b0000001;  // mul/div, unsupported

  localparam logic [11:0] immEcall  = 12'h000;
  localparam logic [11:0] immEbreak = 12'h001;
  localparam logic [11:0] immMret   = 12'h302;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } rType_t;

  typedef struct packed {
    logic [11:0] imm12;  // also csr address / system imm
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } iType_t;

  typedef struct packed {
    logic [6:0] immHi;   // imm[11:5]
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;   // imm[4:0]
    opcode_e    opcode;
  } sType_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    opcode_e     opcode;
  } uType_t;

  typedef union packed {
    rType_t r;
    iType_t i;
    sType_t s;
    uType_t u;
  } instr_u;

endpackage

`default_nettype wire
